// File: bench/afu_tb.sv
// AFU front end testbench
// LFSR command stimulus, a host model with delayed responses, and output checks

`timescale 1ns/1ps

`include "afu_consts.svh"

module afu_tb
	import afu_pkg::*;
();

	logic          clock = 1'b0;
	logic          rstn;
	logic          enabled_in;
	cmd_line_t     read_command_in;
	cmd_line_t     write_command_in;
	host_rsp_t     response_in = '0;
	host_cmd_t     command_out;
	rsp_line_t     read_response_out;
	rsp_line_t     write_response_out;
	cmd_q_status_t command_status;

	// Reference and host model state
	logic [15:0]   lfsr = 16'd33783;
	cmd_line_t     exp_read_cmds[$];
	cmd_line_t     exp_write_cmds[$];
	rsp_line_t     exp_read_rsps[$];
	rsp_line_t     exp_write_rsps[$];
	cmd_class_t    issued_classes[$];
	logic [7:0]    out_tags[$];
	logic [15:0]   out_busy = '0;
	cmd_class_t    out_class [16];
	logic [7:0]    out_cu [16];
	host_rsp_t     next_rsp = '0;
	int            issued_count = 0;
	int            host_delay = 0;
	bit            host_on = 1'b0;
	int            errors = 0;

	afu_top uut (
		.clock             (clock             ),
		.rstn              (rstn              ),
		.enabled_in        (enabled_in        ),
		.read_command_in   (read_command_in   ),
		.write_command_in  (write_command_in  ),
		.response_in       (response_in       ),
		.command_out       (command_out       ),
		.read_response_out (read_response_out ),
		.write_response_out(write_response_out),
		.command_status    (command_status    )
	);

	always #4 clock = ~clock;

//////////////////////////////
// Helpers
//////////////////////////////

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[62:0], fb};
		end
		return r;
	endfunction

	task automatic stop_run(input string line);
		errors++;
		$display("%s", line);
		$display("Test failures found");
		$fatal(1);
	endtask

	// Expected host command from the head of the class queue
	function automatic host_cmd_t predict_command(input cmd_class_t cls, input logic [7:0] tag);
		cmd_line_t src;
		host_cmd_t exp;
		if (cls == CLASS_READ) begin
			src = exp_read_cmds[0];
			exp.code = `AFU_CMD_READ;
		end else begin
			src = exp_write_cmds[0];
			exp.code = `AFU_CMD_WRITE;
		end
		exp.valid   = 1'b1;
		exp.tag     = tag;
		exp.address = src.address;
		exp.size    = src.size;
		return exp;
	endfunction

	// Queue flags for a given number of stored commands
	function automatic queue_status_t expected_status(input int occupancy);
		queue_status_t s;
		s.full   = (occupancy == `AFU_CMD_Q_DEPTH);
		s.alfull = ((`AFU_CMD_Q_DEPTH - occupancy) <= `AFU_ALFULL_ROOM);
		s.empty  = (occupancy == 0);
		return s;
	endfunction

	// Round robin order starting at read, with both queues loaded up front
	function automatic cmd_class_t rr_class(input int idx, input int n_read, input int n_write);
		int         r;
		int         w;
		cmd_class_t turn;
		cmd_class_t cls;
		r = n_read;
		w = n_write;
		turn = CLASS_READ;
		cls = CLASS_READ;
		for (int i = 0; i <= idx; i++) begin
			if ((turn == CLASS_READ && r > 0) || (turn == CLASS_WRITE && w == 0)) begin
				cls = CLASS_READ;
				r--;
				turn = CLASS_WRITE;
			end else begin
				cls = CLASS_WRITE;
				w--;
				turn = CLASS_READ;
			end
		end
		return cls;
	endfunction

	function automatic bit drained();
		return exp_read_cmds.size() == 0 && exp_write_cmds.size() == 0 &&
			out_tags.size() == 0 && exp_read_rsps.size() == 0 && exp_write_rsps.size() == 0;
	endfunction

//////////////////////////////
// Stimulus and waits
//////////////////////////////

	task automatic push_command(input cmd_class_t cls);
		cmd_line_t line;
		int        cycles;
		@(posedge clock);
		line.valid   = 1'b1;
		line.cu_id   = `AFU_CU_W'(rand_bits(`AFU_CU_W));
		line.address = `AFU_ADDR_W'(rand_bits(`AFU_ADDR_W));
		line.size    = `AFU_SIZE_W'(rand_bits(`AFU_SIZE_W));
		cycles = 0;
		@(negedge clock);
		while ((cls == CLASS_READ) ? command_status.read.full : command_status.write.full) begin
			@(negedge clock);
			cycles++;
			if (cycles > 500) begin
				stop_run("Timed out waiting for room in a command queue");
			end
		end
		@(posedge clock);
		if (cls == CLASS_READ) begin
			read_command_in <= line;
			exp_read_cmds.push_back(line);
		end else begin
			write_command_in <= line;
			exp_write_cmds.push_back(line);
		end
		@(posedge clock);
		read_command_in  <= '0;
		write_command_in <= '0;
	endtask

	task automatic wait_issued(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (issued_count < count) begin
			@(posedge clock);
			cycles++;
			if (cycles > limit) begin
				stop_run("Timed out waiting for commands to issue");
			end
		end
	endtask

	task automatic wait_drained(input int limit);
		int cycles;
		cycles = 0;
		while (!drained()) begin
			@(posedge clock);
			cycles++;
			if (cycles > limit) begin
				stop_run("Timed out waiting for all commands and responses to finish");
			end
		end
	endtask

//////////////////////////////
// Output checks and host model
//////////////////////////////

	task automatic check_outputs();
		cmd_class_t    cls;
		host_cmd_t     expected;
		cmd_line_t     src;
		logic [3:0]    slot;
		cmd_q_status_t exp_status;
		if (command_out.valid) begin
			assert (command_out.code == `AFU_CMD_READ || command_out.code == `AFU_CMD_WRITE)
				else stop_run($sformatf("** Error at %0t: bad command code %h", $time,
					command_out.code));
			if (command_out.code == `AFU_CMD_READ) begin
				cls = CLASS_READ;
			end else begin
				cls = CLASS_WRITE;
			end
			assert (command_out.tag < `AFU_NUM_TAGS && !out_busy[command_out.tag[3:0]])
				else stop_run($sformatf("** Error at %0t: tag %0d issued while in use", $time,
					command_out.tag));
			assert ((cls == CLASS_READ) ? exp_read_cmds.size() > 0 : exp_write_cmds.size() > 0)
				else stop_run("A command issued that was never pushed");
			expected = predict_command(cls, command_out.tag);
			assert (command_out == expected)
				else stop_run($sformatf("** Error at %0t: command %h, expected %h", $time,
					command_out, expected));
			if (cls == CLASS_READ) begin
				src = exp_read_cmds.pop_front();
			end else begin
				src = exp_write_cmds.pop_front();
			end
			slot = command_out.tag[3:0];
			out_busy[slot]  = 1'b1;
			out_class[slot] = cls;
			out_cu[slot]    = src.cu_id;
			out_tags.push_back(command_out.tag);
			issued_classes.push_back(cls);
			issued_count++;
		end
		// A command driven this cycle is not stored until the next edge
		exp_status.read  = expected_status(exp_read_cmds.size() - int'(read_command_in.valid));
		exp_status.write = expected_status(exp_write_cmds.size() - int'(write_command_in.valid));
		assert (command_status == exp_status)
			else stop_run($sformatf("** Error at %0t: queue status %b, expected %b", $time,
				command_status, exp_status));
		if (read_response_out.valid) begin
			assert (exp_read_rsps.size() > 0)
				else stop_run("A read response came out with none expected");
			assert (read_response_out == exp_read_rsps[0])
				else stop_run($sformatf("** Error at %0t: read response %h, expected %h", $time,
					read_response_out, exp_read_rsps[0]));
			exp_read_rsps.delete(0);
		end
		if (write_response_out.valid) begin
			assert (exp_write_rsps.size() > 0)
				else stop_run("A write response came out with none expected");
			assert (write_response_out == exp_write_rsps[0])
				else stop_run($sformatf("** Error at %0t: write response %h, expected %h", $time,
					write_response_out, exp_write_rsps[0]));
			exp_write_rsps.delete(0);
		end
	endtask

	// Answers one outstanding tag, picked at random, after a random gap
	task automatic host_step();
		int         idx;
		logic [7:0] tag;
		rsp_line_t  line;
		next_rsp = '0;
		if (host_on && out_tags.size() > 0) begin
			if (host_delay > 0) begin
				host_delay--;
			end else begin
				idx = int'(rand_bits(4)) % out_tags.size();
				tag = out_tags[idx];
				out_tags.delete(idx);
				out_busy[tag[3:0]] = 1'b0;
				next_rsp.valid   = 1'b1;
				next_rsp.tag     = tag;
				next_rsp.code    = `AFU_RSP_W'(rand_bits(`AFU_RSP_W));
				next_rsp.credits = `AFU_CREDIT_W'(1);
				line.valid = 1'b1;
				line.cu_id = out_cu[tag[3:0]];
				line.code  = next_rsp.code;
				line.tag   = tag;
				if (out_class[tag[3:0]] == CLASS_READ) begin
					exp_read_rsps.push_back(line);
				end else begin
					exp_write_rsps.push_back(line);
				end
				host_delay = int'(rand_bits(3));
			end
		end
	endtask

	always @(negedge clock) begin
		if (rstn) begin
			check_outputs();
			host_step();
		end
	end

	always @(posedge clock) begin
		response_in <= next_rsp;
	end

//////////////////////////////
// Test sequence
//////////////////////////////

	initial begin
		rstn             = 1'b0;
		enabled_in       = 1'b0;
		read_command_in  = '0;
		write_command_in = '0;
		repeat (16) @(posedge clock);
		rstn <= 1'b1;

		@(negedge clock);
		assert (!command_out.valid && !read_response_out.valid && !write_response_out.valid)
			else stop_run("An output was valid right after reset");
		assert (command_status.read.empty && command_status.write.empty)
			else stop_run("A command queue was not empty after reset");

		// Load both queues while disabled
		repeat (3) push_command(CLASS_READ);
		repeat (5) push_command(CLASS_WRITE);
		repeat (40) @(posedge clock);
		assert (issued_count == 0)
			else stop_run($sformatf("** Error at %0t: %0d commands issued while disabled",
				$time, issued_count));

		// Enable with responses held back, credits run out after eight
		enabled_in <= 1'b1;
		wait_issued(8, 200);
		for (int i = 0; i < 8; i++) begin
			assert (issued_classes[i] == rr_class(i, 3, 5))
				else stop_run($sformatf("** Error at %0t: issue %0d had the wrong class",
					$time, i));
		end
		repeat (2) push_command(CLASS_READ);
		repeat (40) @(posedge clock);
		assert (issued_count == `AFU_CMD_CREDITS)
			else stop_run($sformatf("** Error at %0t: %0d issued with no credits left",
				$time, issued_count));
		host_on = 1'b1;
		wait_drained(2000);

		// Random traffic with the host answering
		for (int n = 0; n < 40; n++) begin
			if (rand_bits(1) != '0) begin
				push_command(CLASS_WRITE);
			end else begin
				push_command(CLASS_READ);
			end
			repeat (int'(rand_bits(2))) @(posedge clock);
		end
		wait_drained(3000);

		// Fill the write queue while disabled, flags pass almost-full to full
		enabled_in <= 1'b0;
		repeat (`AFU_CMD_Q_DEPTH) push_command(CLASS_WRITE);
		enabled_in <= 1'b1;
		wait_drained(3000);
		assert (issued_count == 66)
			else stop_run($sformatf("** Error at %0t: %0d commands issued, expected 66",
				$time, issued_count));

		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+hw
hw/afu_pkg.sv
hw/sync_fifo.sv
hw/tag_pool.sv
hw/afu_control.sv
hw/afu_top.sv
bench/afu_tb.sv

// File: hw/afu_consts.svh
// AFU command front end constants
// Sizes, field widths, command codes and the host credit count

`ifndef AFU_CONSTS_SVH
`define AFU_CONSTS_SVH

// Field widths
`define AFU_ADDR_W 64
`define AFU_SIZE_W 12
`define AFU_TAG_W 8
`define AFU_CU_W 8
`define AFU_CODE_W 13
`define AFU_RSP_W 8
`define AFU_CREDIT_W 9

// Tag pool size
`define AFU_NUM_TAGS 16

// Host command codes, 13 bits wide
`define AFU_CMD_READ 13'h0A00
`define AFU_CMD_WRITE 13'h0D00

// Host grants this many commands after reset
`define AFU_CMD_CREDITS 8

// Queue depths
`define AFU_CMD_Q_DEPTH 16
`define AFU_RSP_Q_DEPTH 16

// Almost-full rises with this many free slots left
`define AFU_ALFULL_ROOM 2

`endif

// File: hw/afu_control.sv
// AFU command control
// Enable register, round-robin pick between read and write queues,
// host credit counter and the registered command to the host

`timescale 1ns/1ps

`include "afu_consts.svh"

module afu_control
	import afu_pkg::*;
(
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enabled_in,
	input  cmd_line_t                read_head,
	input  cmd_line_t                write_head,
	input  cmd_q_status_t            q_status,
	input  logic [`AFU_TAG_W-1:0]    free_tag,
	input  logic                     tag_ready,
	input  logic [`AFU_CREDIT_W-1:0] credit_return,
	output logic                     read_pop,
	output logic                     write_pop,
	output logic                     alloc,
	output cmd_class_t               alloc_class,
	output logic [`AFU_CU_W-1:0]     alloc_cu_id,
	output host_cmd_t                command_out
);

	localparam int CREDIT_W = `AFU_CREDIT_W;
	localparam int CODE_W   = `AFU_CODE_W;

	localparam logic [CREDIT_W-1:0] MAX_CREDITS = `AFU_CMD_CREDITS;
	localparam logic [CODE_W-1:0]   READ_CODE   = `AFU_CMD_READ;
	localparam logic [CODE_W-1:0]   WRITE_CODE  = `AFU_CMD_WRITE;

	logic                     enabled;
	logic [CREDIT_W-1:0]      credits;
	logic [CREDIT_W-1:0]      credits_next;
	cmd_class_t               favour;
	cmd_class_t               grant;
	cmd_line_t                grant_head;
	logic                     read_req;
	logic                     write_req;
	logic                     issue;

	// Registered host command
	logic                     cmd_valid;
	logic [`AFU_TAG_W-1:0]    cmd_tag;
	logic [CODE_W-1:0]        cmd_code;
	logic [`AFU_ADDR_W-1:0]   cmd_addr;
	logic [`AFU_SIZE_W-1:0]   cmd_size;

////////////////////////////////
// Arbitration
////////////////////////////////

	assign read_req  = !q_status.read.empty;
	assign write_req = !q_status.write.empty;

	// Issue needs enable, a credit and a tag
	assign issue = enabled && (credits != '0) && tag_ready && (read_req || write_req);

	always_comb begin
		if (favour == CLASS_READ) begin
			grant = read_req ? CLASS_READ : CLASS_WRITE;
		end else begin
			grant = write_req ? CLASS_WRITE : CLASS_READ;
		end
	end

	assign grant_head  = (grant == CLASS_READ) ? read_head : write_head;
	assign read_pop    = issue && (grant == CLASS_READ);
	assign write_pop   = issue && (grant == CLASS_WRITE);
	assign alloc       = issue;
	assign alloc_class = grant;
	assign alloc_cu_id = grant_head.cu_id;

////////////////////////////////
// Credits and state
////////////////////////////////

	always_comb begin
		credits_next = credits + credit_return;
		if (issue) begin
			credits_next = credits_next - 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled   <= 1'b0;
			credits   <= MAX_CREDITS;
			favour    <= CLASS_READ;
			cmd_valid <= 1'b0;
		end else begin
			enabled   <= enabled_in;
			credits   <= credits_next;
			cmd_valid <= issue;
			if (issue) begin
				favour <= (grant == CLASS_READ) ? CLASS_WRITE : CLASS_READ;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			cmd_tag  <= free_tag;
			cmd_code <= (grant == CLASS_READ) ? READ_CODE : WRITE_CODE;
			cmd_addr <= grant_head.address;
			cmd_size <= grant_head.size;
		end
	end

	assign command_out = '{valid: cmd_valid, tag: cmd_tag, code: cmd_code,
		address: cmd_addr, size: cmd_size};

	a_credit_max: assert property (@(posedge clock) disable iff (!rstn) credits <= MAX_CREDITS)
		else $error("host returned more credits than granted");

endmodule

// File: hw/afu_pkg.sv
// AFU front end types
// Command, host and response lines plus queue status words

`include "afu_consts.svh"

package afu_pkg;

	// Command from a compute unit
	typedef struct packed {
		logic                     valid;
		logic [`AFU_CU_W-1:0]     cu_id;
		logic [`AFU_ADDR_W-1:0]   address;
		logic [`AFU_SIZE_W-1:0]   size;
	} cmd_line_t;

	// Command issued to the host
	typedef struct packed {
		logic                     valid;
		logic [`AFU_TAG_W-1:0]    tag;
		logic [`AFU_CODE_W-1:0]   code;
		logic [`AFU_ADDR_W-1:0]   address;
		logic [`AFU_SIZE_W-1:0]   size;
	} host_cmd_t;

	// Response from the host, credits are returned here
	typedef struct packed {
		logic                     valid;
		logic [`AFU_TAG_W-1:0]    tag;
		logic [`AFU_RSP_W-1:0]    code;
		logic [`AFU_CREDIT_W-1:0] credits;
	} host_rsp_t;

	// Response routed back to a compute unit
	typedef struct packed {
		logic                     valid;
		logic [`AFU_CU_W-1:0]     cu_id;
		logic [`AFU_RSP_W-1:0]    code;
		logic [`AFU_TAG_W-1:0]    tag;
	} rsp_line_t;

	typedef enum logic [0:0] {
		CLASS_READ  = 1'b0,
		CLASS_WRITE = 1'b1
	} cmd_class_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
	} queue_status_t;

	typedef struct packed {
		queue_status_t read;
		queue_status_t write;
	} cmd_q_status_t;

endpackage

// File: hw/afu_top.sv
// AFU command and response front end
// Command queues per class, issue control, tag pool and response queues

`timescale 1ns/1ps

`include "afu_consts.svh"

module afu_top
	import afu_pkg::*;
(
	input  logic          clock,
	input  logic          rstn,
	input  logic          enabled_in,
	input  cmd_line_t     read_command_in,
	input  cmd_line_t     write_command_in,
	input  host_rsp_t     response_in,
	output host_cmd_t     command_out,
	output rsp_line_t     read_response_out,
	output rsp_line_t     write_response_out,
	output cmd_q_status_t command_status
);

	cmd_line_t                read_head;
	cmd_line_t                write_head;
	logic                     read_pop;
	logic                     write_pop;
	logic                     alloc;
	cmd_class_t               alloc_class;
	logic [`AFU_CU_W-1:0]     alloc_cu_id;
	logic [`AFU_TAG_W-1:0]    free_tag;
	logic                     tag_ready;
	logic [`AFU_CREDIT_W-1:0] credit_return;
	host_rsp_t                response_q;
	rsp_line_t                rsp_line;
	logic                     read_rsp_push;
	logic                     write_rsp_push;
	logic                     read_rsp_empty;
	logic                     write_rsp_empty;

	// Host response input register
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_q <= '0;
		end else begin
			response_q <= response_in;
		end
	end

////////////////////////////////
// Command queues
////////////////////////////////

	sync_fifo #(.WIDTH($bits(cmd_line_t)), .DEPTH(`AFU_CMD_Q_DEPTH)) read_cmd_fifo (
		.clock   (clock                        ),
		.rstn    (rstn                         ),
		.push    (read_command_in.valid        ),
		.data_in (read_command_in              ),
		.pop     (read_pop                     ),
		.data_out(read_head                    ),
		.full    (command_status.read.full     ),
		.alfull  (command_status.read.alfull   ),
		.empty   (command_status.read.empty    )
	);

	sync_fifo #(.WIDTH($bits(cmd_line_t)), .DEPTH(`AFU_CMD_Q_DEPTH)) write_cmd_fifo (
		.clock   (clock                        ),
		.rstn    (rstn                         ),
		.push    (write_command_in.valid       ),
		.data_in (write_command_in             ),
		.pop     (write_pop                    ),
		.data_out(write_head                   ),
		.full    (command_status.write.full    ),
		.alfull  (command_status.write.alfull  ),
		.empty   (command_status.write.empty   )
	);

////////////////////////////////
// Issue control and tags
////////////////////////////////

	afu_control control (
		.clock        (clock         ),
		.rstn         (rstn          ),
		.enabled_in   (enabled_in    ),
		.read_head    (read_head     ),
		.write_head   (write_head    ),
		.q_status     (command_status),
		.free_tag     (free_tag      ),
		.tag_ready    (tag_ready     ),
		.credit_return(credit_return ),
		.read_pop     (read_pop      ),
		.write_pop    (write_pop     ),
		.alloc        (alloc         ),
		.alloc_class  (alloc_class   ),
		.alloc_cu_id  (alloc_cu_id   ),
		.command_out  (command_out   )
	);

	tag_pool tags (
		.clock         (clock         ),
		.rstn          (rstn          ),
		.alloc         (alloc         ),
		.alloc_class   (alloc_class   ),
		.alloc_cu_id   (alloc_cu_id   ),
		.response      (response_q    ),
		.free_tag      (free_tag      ),
		.tag_ready     (tag_ready     ),
		.rsp_line      (rsp_line      ),
		.read_rsp_push (read_rsp_push ),
		.write_rsp_push(write_rsp_push),
		.credit_return (credit_return )
	);

////////////////////////////////
// Response queues
////////////////////////////////

	// Drained every cycle, so each entry shows for one cycle
	sync_fifo #(.WIDTH($bits(rsp_line_t)), .DEPTH(`AFU_RSP_Q_DEPTH)) read_rsp_fifo (
		.clock   (clock            ),
		.rstn    (rstn             ),
		.push    (read_rsp_push    ),
		.data_in (rsp_line         ),
		.pop     (!read_rsp_empty  ),
		.data_out(read_response_out),
		.full    (                 ),
		.alfull  (                 ),
		.empty   (read_rsp_empty   )
	);

	sync_fifo #(.WIDTH($bits(rsp_line_t)), .DEPTH(`AFU_RSP_Q_DEPTH)) write_rsp_fifo (
		.clock   (clock             ),
		.rstn    (rstn              ),
		.push    (write_rsp_push    ),
		.data_in (rsp_line          ),
		.pop     (!write_rsp_empty  ),
		.data_out(write_response_out),
		.full    (                  ),
		.alfull  (                  ),
		.empty   (write_rsp_empty   )
	);

endmodule

// File: hw/sync_fifo.sv
// Synchronous FIFO, first word fall through
// Ring buffer with an occupancy counter and full, almost-full, empty flags

`timescale 1ns/1ps

`include "afu_consts.svh"

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int AW           = $clog2(DEPTH);
	localparam int CW           = $clog2(DEPTH + 1);
	localparam int ALFULL_LEVEL = DEPTH - `AFU_ALFULL_ROOM;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full   = (count == CW'(DEPTH));
	assign alfull = (count >= CW'(ALFULL_LEVEL));
	assign empty  = (count == '0);

	// Head word, zero while nothing is stored
	assign data_out = empty ? '0 : mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	a_no_push_full: assert property (@(posedge clock) disable iff (!rstn) !(push && full))
		else $error("push into a full queue");
	a_no_pop_empty: assert property (@(posedge clock) disable iff (!rstn) !(pop && empty))
		else $error("pop from an empty queue");

endmodule

// File: hw/tag_pool.sv
// Tag pool for outstanding host commands
// Hands out the lowest free tag, records class and cu id per tag,
// and routes host responses back to the queue of their class

`timescale 1ns/1ps

`include "afu_consts.svh"

module tag_pool
	import afu_pkg::*;
(
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     alloc,
	input  cmd_class_t               alloc_class,
	input  logic [`AFU_CU_W-1:0]     alloc_cu_id,
	input  host_rsp_t                response,
	output logic [`AFU_TAG_W-1:0]    free_tag,
	output logic                     tag_ready,
	output rsp_line_t                rsp_line,
	output logic                     read_rsp_push,
	output logic                     write_rsp_push,
	output logic [`AFU_CREDIT_W-1:0] credit_return
);

	localparam int NUM_TAGS = `AFU_NUM_TAGS;
	localparam int IDX_W    = $clog2(NUM_TAGS);
	localparam int TAG_W    = `AFU_TAG_W;

	logic [NUM_TAGS-1:0]  busy;
	logic [NUM_TAGS-1:0]  busy_next;
	logic [IDX_W-1:0]     free_idx;
	logic [IDX_W-1:0]     resp_idx;

	// Per-tag record
	cmd_class_t           tag_class [NUM_TAGS];
	logic [`AFU_CU_W-1:0] tag_cu    [NUM_TAGS];

////////////////////////////////
// Free tag search
////////////////////////////////

	// Lowest clear bit wins
	always_comb begin
		free_idx = '0;
		for (int i = NUM_TAGS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_idx = IDX_W'(i);
			end
		end
	end

	assign free_tag  = TAG_W'(free_idx);
	assign tag_ready = ~&busy;
	assign resp_idx  = response.tag[IDX_W-1:0];

////////////////////////////////
// Busy bitmap and records
////////////////////////////////

	always_comb begin
		busy_next = busy;
		if (alloc) begin
			busy_next[free_idx] = 1'b1;
		end
		// Freed tags show up as free one cycle later
		if (response.valid) begin
			busy_next[resp_idx] = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (alloc) begin
			tag_class[free_idx] <= alloc_class;
			tag_cu[free_idx]    <= alloc_cu_id;
		end
	end

////////////////////////////////
// Response routing
////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy           <= '0;
			rsp_line       <= '0;
			read_rsp_push  <= 1'b0;
			write_rsp_push <= 1'b0;
			credit_return  <= '0;
		end else begin
			busy           <= busy_next;
			rsp_line       <= '0;
			read_rsp_push  <= 1'b0;
			write_rsp_push <= 1'b0;
			credit_return  <= '0;
			if (response.valid) begin
				rsp_line.valid <= 1'b1;
				rsp_line.cu_id <= tag_cu[resp_idx];
				rsp_line.code  <= response.code;
				rsp_line.tag   <= response.tag;
				read_rsp_push  <= (tag_class[resp_idx] == CLASS_READ);
				write_rsp_push <= (tag_class[resp_idx] == CLASS_WRITE);
				credit_return  <= response.credits;
			end
		end
	end

	a_alloc_ready: assert property (@(posedge clock) disable iff (!rstn) alloc |-> tag_ready)
		else $error("tag allocated with no free tag");
	a_rsp_busy: assert property (@(posedge clock) disable iff (!rstn)
		response.valid |-> busy[resp_idx])
		else $error("response for a tag that is not outstanding");

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the AFU front end testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module afu_tb -o afu_sim -f compile.f \
	> build.log 2>&1 || { cat build.log; echo "FAIL: build"; exit 1; }
./obj_dir/afu_sim > sim.log 2>&1
cat sim.log
grep -q 'Test failures found' sim.log && { echo "FAIL"; exit 1; }
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL: no result"; exit 1; }
